//--- source/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int TAG_W  = 8;

    // execute function codes
    typedef enum logic [4:0] {
        ALU_NOP    = 5'd0,
        ALU_ADD    = 5'd1,
        ALU_SUB    = 5'd2,
        ALU_AND    = 5'd3,
        ALU_OR     = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SLL    = 5'd6,
        ALU_SRL    = 5'd7,
        ALU_SRA    = 5'd8,
        ALU_SLT    = 5'd9,
        ALU_SLTU   = 5'd10,
        ALU_JALR   = 5'd11,
        ALU_COPY1  = 5'd12,
        BR_BEQ     = 5'd13,
        BR_BNE     = 5'd14,
        BR_BLT     = 5'd15,
        BR_BGE     = 5'd16,
        BR_BLTU    = 5'd17,
        BR_BGEU    = 5'd18,
        ALU_MUL    = 5'd19,
        ALU_MULH   = 5'd20,
        ALU_MULHSU = 5'd21,
        ALU_MULHU  = 5'd22,
        ALU_DIV    = 5'd23,
        ALU_DIVU   = 5'd24,
        ALU_REM    = 5'd25,
        ALU_REMU   = 5'd26
    } exe_fun_e;

    // bundle from decode
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        exe_fun_e          fun;
        logic [XLEN-1:0]   op1;
        logic [XLEN-1:0]   op2;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm_b;
        logic [REG_AW-1:0] rd;
        logic              rf_wen;
        logic [TAG_W-1:0]  tag;
    } ex_in_t;

    // bundle to the memory stage
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   alu_out;
        logic [XLEN-1:0]   rs2_data;
        logic [REG_AW-1:0] rd;
        logic              rf_wen;
        logic [TAG_W-1:0]  tag;
    } ex_out_t;

endpackage

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu (
    input  wire rv_exec_pkg::exe_fun_e fun,
    input  wire [31:0]                 op1,
    input  wire [31:0]                 op2,
    input  wire [31:0]                 pc,
    input  wire [31:0]                 imm_b,
    output logic [31:0]                result,
    output logic                       br_taken,
    output logic [31:0]                br_target
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] sum;
    logic            lt_s;
    logic            lt_u;
    logic            eq;

    assign sum  = op1 + op2;
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;
    assign eq   = op1 == op2;

    always_comb begin
        case (fun)
            ALU_ADD:   result = sum;
            ALU_SUB:   result = op1 - op2;
            ALU_AND:   result = op1 & op2;
            ALU_OR:    result = op1 | op2;
            ALU_XOR:   result = op1 ^ op2;
            ALU_SLL:   result = op1 << op2[4:0];
            ALU_SRL:   result = op1 >> op2[4:0];
            ALU_SRA:   result = $unsigned($signed(op1) >>> op2[4:0]);
            ALU_SLT:   result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:  result = {{(XLEN-1){1'b0}}, lt_u};
            // jalr target with bit 0 cleared
            ALU_JALR:  result = {sum[XLEN-1:1], 1'b0};
            ALU_COPY1: result = op1;
            default:   result = '0;
        endcase
    end

    always_comb begin
        case (fun)
            BR_BEQ:  br_taken = eq;
            BR_BNE:  br_taken = !eq;
            BR_BLT:  br_taken = lt_s;
            BR_BGE:  br_taken = !lt_s;
            BR_BLTU: br_taken = lt_u;
            BR_BGEU: br_taken = !lt_u;
            default: br_taken = 1'b0;
        endcase
    end

    assign br_target = pc + imm_b;

endmodule

`default_nettype wire

//--- source/mul_unit.sv
`default_nettype none

module mul_unit #(
    parameter int WIDTH = 33
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start,
    input  wire                 is_signed,
    input  wire [WIDTH-1:0]     a,
    input  wire [WIDTH-1:0]     b,
    output logic                ready,
    output logic                valid,
    output logic [2*WIDTH-1:0]  product
);

    localparam int CW = $clog2(WIDTH + 1);

    logic               busy;
    logic [CW-1:0]      count;
    logic               last;
    logic               sgn;
    logic [2*WIDTH-1:0] mcand;
    logic [WIDTH-1:0]   mplier;
    logic [2*WIDTH-1:0] acc;

    assign last  = count == CW'(WIDTH - 1);
    assign ready = !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            valid <= 1'b0;
            count <= '0;
        end else begin
            valid <= busy && last;
            if (start && !busy) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                busy  <= !last;
                count <= count + 1'b1;
            end
        end
    end

    // one multiplier bit per cycle, lsb first
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            sgn    <= is_signed;
            mcand  <= is_signed ? {{WIDTH{a[WIDTH-1]}}, a} : {{WIDTH{1'b0}}, a};
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                // signed msb weighs -2^(WIDTH-1)
                acc <= (last && sgn) ? acc - mcand : acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

//--- source/div_unit.sv
`default_nettype none

module div_unit #(
    parameter int WIDTH = 33
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              start,
    input  wire              is_signed,
    input  wire [WIDTH-1:0]  dividend,
    input  wire [WIDTH-1:0]  divisor,
    output logic             ready,
    output logic             valid,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);

    localparam int CW = $clog2(WIDTH + 1);

    logic             busy;
    logic [CW-1:0]    count;
    logic             last;
    logic             a_neg;
    logic             b_neg;
    logic [WIDTH-1:0] a_mag;
    logic [WIDTH-1:0] b_mag;
    logic             neg_q;
    logic             neg_r;
    logic [WIDTH-1:0] dsor;
    logic [WIDTH-1:0] quo;
    logic [WIDTH-1:0] rem;
    logic [WIDTH:0]   rem_sh;
    logic [WIDTH:0]   diff;

    assign a_neg = is_signed && dividend[WIDTH-1];
    assign b_neg = is_signed && divisor[WIDTH-1];
    assign a_mag = a_neg ? -dividend : dividend;
    assign b_mag = b_neg ? -divisor : divisor;

    assign last  = count == CW'(WIDTH - 1);
    assign ready = !busy;

    // quo starts as the dividend and shifts into the partial remainder
    assign rem_sh = {rem, quo[WIDTH-1]};
    assign diff   = rem_sh - {1'b0, dsor};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            valid <= 1'b0;
            count <= '0;
        end else begin
            valid <= busy && last;
            if (start && !busy) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                busy  <= !last;
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            // zero divisor keeps the all-ones quotient unsigned
            neg_q <= (a_neg ^ b_neg) && (divisor != '0);
            neg_r <= a_neg;
            dsor  <= b_mag;
            quo   <= a_mag;
            rem   <= '0;
        end else if (busy) begin
            if (!diff[WIDTH]) begin
                rem <= diff[WIDTH-1:0];
                quo <= {quo[WIDTH-2:0], 1'b1};
            end else begin
                rem <= rem_sh[WIDTH-1:0];
                quo <= {quo[WIDTH-2:0], 1'b0};
            end
        end
    end

    // sign fix-up
    assign quotient  = neg_q ? -quo : quo;
    assign remainder = neg_r ? -rem : rem;

endmodule

`default_nettype wire

//--- source/ex_stage.sv
`default_nettype none

module ex_stage #(
    parameter int WIDTH = 33
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire rv_exec_pkg::ex_in_t  in,
    input  wire                       mem_stall,
    input  wire                       flush,
    output rv_exec_pkg::ex_out_t      out,
    output logic                      br_taken,
    output logic [31:0]               br_target,
    output logic                      stall
);
    import rv_exec_pkg::*;

    localparam int EXT = WIDTH - XLEN;

    ex_in_t             saved;
    logic               use_saved;
    ex_in_t             cur;

    logic               is_mul;
    logic               is_div;
    logic               mul_a_sgn;
    logic               mul_b_sgn;
    logic               div_sgn;
    logic               mul_high;
    logic               div_rem;

    logic               mul_start;
    logic               mul_ready;
    logic               mul_valid;
    logic [WIDTH-1:0]   mul_a;
    logic [WIDTH-1:0]   mul_b;
    logic [2*WIDTH-1:0] product;

    logic               div_start;
    logic               div_ready;
    logic               div_valid;
    logic [WIDTH-1:0]   div_a;
    logic [WIDTH-1:0]   div_b;
    logic [WIDTH-1:0]   quotient;
    logic [WIDTH-1:0]   remainder;

    logic               calc_busy;
    logic               calc_done;
    logic               calc_end;
    logic [XLEN-1:0]    calc_res;
    logic [XLEN-1:0]    m_live;

    logic [XLEN-1:0]    alu_result;
    logic               alu_br_taken;
    logic [XLEN-1:0]    alu_br_target;
    logic [XLEN-1:0]    result;
    logic               fire;
    logic               out_valid;
    ex_out_t            out_q;

    // replay the held copy after a hold cycle
    assign cur = use_saved ? saved : in;

    assign is_mul    = cur.fun inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    assign is_div    = cur.fun inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    assign mul_a_sgn = cur.fun inside {ALU_MUL, ALU_MULH, ALU_MULHSU};
    assign mul_b_sgn = cur.fun inside {ALU_MUL, ALU_MULH};
    assign div_sgn   = cur.fun inside {ALU_DIV, ALU_REM};
    assign mul_high  = cur.fun != ALU_MUL;
    assign div_rem   = cur.fun inside {ALU_REM, ALU_REMU};

    assign mul_a = {{EXT{mul_a_sgn & cur.op1[XLEN-1]}}, cur.op1};
    assign mul_b = {{EXT{mul_b_sgn & cur.op2[XLEN-1]}}, cur.op2};
    assign div_a = {{EXT{div_sgn & cur.op1[XLEN-1]}}, cur.op1};
    assign div_b = {{EXT{div_sgn & cur.op2[XLEN-1]}}, cur.op2};

    assign mul_start = cur.valid && is_mul && !calc_busy && !calc_done && mul_ready && !flush;
    assign div_start = cur.valid && is_div && !calc_busy && !calc_done && div_ready && !flush;

    assign calc_end = calc_busy && (is_div ? div_valid : mul_valid);
    assign m_live   = is_div ? (div_rem ? remainder[XLEN-1:0] : quotient[XLEN-1:0])
                             : (mul_high ? product[2*XLEN-1:XLEN] : product[XLEN-1:0]);

    assign stall  = cur.valid && (is_mul || is_div) && !calc_done && !calc_end;
    assign fire   = cur.valid && !stall && !mem_stall && !flush;
    assign result = (is_mul || is_div) ? (calc_done ? calc_res : m_live) : alu_result;

    alu u_alu (
        .fun       (cur.fun),
        .op1       (cur.op1),
        .op2       (cur.op2),
        .pc        (cur.pc),
        .imm_b     (cur.imm_b),
        .result    (alu_result),
        .br_taken  (alu_br_taken),
        .br_target (alu_br_target)
    );

    mul_unit #(.WIDTH(WIDTH)) u_mul_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (mul_start),
        .is_signed (mul_a_sgn),
        .a         (mul_a),
        .b         (mul_b),
        .ready     (mul_ready),
        .valid     (mul_valid),
        .product   (product)
    );

    div_unit #(.WIDTH(WIDTH)) u_div_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .is_signed (div_sgn),
        .dividend  (div_a),
        .divisor   (div_b),
        .ready     (div_ready),
        .valid     (div_valid),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            use_saved <= 1'b0;
            calc_busy <= 1'b0;
            calc_done <= 1'b0;
            out_valid <= 1'b0;
            br_taken  <= 1'b0;
        end else if (flush) begin
            use_saved <= 1'b0;
            calc_busy <= 1'b0;
            calc_done <= 1'b0;
            out_valid <= 1'b0;
            br_taken  <= 1'b0;
        end else begin
            use_saved <= cur.valid && (stall || mem_stall);
            if (mul_start || div_start) begin
                calc_busy <= 1'b1;
            end else if (calc_end) begin
                calc_busy <= 1'b0;
            end
            // result finished under a memory stall waits here
            if (calc_end && mem_stall) begin
                calc_done <= 1'b1;
            end else if (fire) begin
                calc_done <= 1'b0;
            end
            out_valid <= fire;
            br_taken  <= fire && alu_br_taken;
        end
    end

    always_ff @(posedge clk) begin
        saved <= cur;
        if (calc_end) begin
            calc_res <= m_live;
        end
        if (fire) begin
            out_q     <= '{valid: 1'b1, pc: cur.pc, alu_out: result, rs2_data: cur.rs2_data,
                           rd: cur.rd, rf_wen: cur.rf_wen, tag: cur.tag};
            br_target <= alu_br_target;
        end
    end

    always_comb begin
        out       = out_q;
        out.valid = out_valid;
    end

endmodule

`default_nettype wire

//--- source/exec_top.sv
`default_nettype none

module exec_top #(
    parameter int OPER_WIDTH = 33
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire rv_exec_pkg::ex_in_t  in,
    input  wire                       mem_stall,
    input  wire                       flush,
    output rv_exec_pkg::ex_out_t      out,
    output logic                      br_taken,
    output logic [31:0]               br_target,
    output logic                      stall
);

    // extra operand bit for mulhsu and signed divide
    ex_stage #(
        .WIDTH (OPER_WIDTH)
    ) u_ex_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (in),
        .mem_stall (mem_stall),
        .flush     (flush),
        .out       (out),
        .br_taken  (br_taken),
        .br_target (br_target),
        .stall     (stall)
    );

endmodule

`default_nettype wire

//--- tb/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic is_mcycle(input exe_fun_e f);
    return f inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
                     ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
endfunction

function automatic logic branch_ref(input exe_fun_e f, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f)
        BR_BEQ:  return a == b;
        BR_BNE:  return a != b;
        BR_BLT:  return $signed(a) < $signed(b);
        BR_BGE:  return $signed(a) >= $signed(b);
        BR_BLTU: return a < b;
        BR_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// rv32im result, zero for branch codes
function automatic logic [31:0] result_ref(input exe_fun_e f, input logic [31:0] a,
                                           input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] ua;
    logic signed [63:0] ub;
    logic signed [63:0] p;
    sa = $signed(a);
    sb = $signed(b);
    ua = {32'b0, a};
    ub = {32'b0, b};
    if (f == ALU_MULH) begin
        p = sa * sb;
    end else if (f == ALU_MULHSU) begin
        p = sa * ub;
    end else begin
        p = ua * ub;
    end
    // 64-bit signed math gives min / -1 its rv32 result directly
    case (f)
        ALU_ADD:    return a + b;
        ALU_SUB:    return a - b;
        ALU_AND:    return a & b;
        ALU_OR:     return a | b;
        ALU_XOR:    return a ^ b;
        ALU_SLL:    return a << b[4:0];
        ALU_SRL:    return a >> b[4:0];
        ALU_SRA:    return 32'(sa >>> b[4:0]);
        ALU_SLT:    return {31'b0, sa < sb};
        ALU_SLTU:   return {31'b0, a < b};
        ALU_JALR:   return (a + b) & ~32'd1;
        ALU_COPY1:  return a;
        ALU_MUL:    return p[31:0];
        ALU_MULH:   return p[63:32];
        ALU_MULHSU: return p[63:32];
        ALU_MULHU:  return p[63:32];
        ALU_DIV:    return (b == '0) ? 32'hffff_ffff : 32'(sa / sb);
        ALU_DIVU:   return (b == '0) ? 32'hffff_ffff : a / b;
        ALU_REM:    return (b == '0) ? a : 32'(sa % sb);
        ALU_REMU:   return (b == '0) ? a : a % b;
        default:    return '0;
    endcase
endfunction

`endif

//--- tb/tb_exec_top.sv
`default_nettype none

module tb_exec_top;
    import rv_exec_pkg::*;

    `include "exec_model.svh"

    localparam int TIMEOUT = 200;
    localparam int N_INSTR = 2000;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_out;
        logic [31:0] rs2_data;
        logic [4:0]  rd;
        logic        rf_wen;
        logic [7:0]  tag;
        logic        br_taken;
        logic [31:0] br_target;
    } exp_t;

    logic        clk;
    logic        rst_n;
    ex_in_t      in_b;
    logic        mem_stall;
    logic        flush;
    ex_out_t     out_b;
    logic        br_taken;
    logic [31:0] br_target;
    logic        stall;

    logic [31:0] lfsr;
    exp_t        exp_q[$];
    int          n_accepted;
    int          hold_cycles;
    int          drain_cycles;
    logic        accept_now;
    logic        flush_now;
    logic [7:0]  next_tag;

    exec_top #(
        .OPER_WIDTH (33)
    ) u_exec_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (in_b),
        .mem_stall (mem_stall),
        .flush     (flush),
        .out       (out_b),
        .br_taken  (br_taken),
        .br_target (br_target),
        .stall     (stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // biased toward the edge values
    function automatic logic [31:0] rand_operand();
        logic [2:0] sel;
        sel = 3'(rand_bits(3));
        case (sel)
            3'd0:    return '0;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            default: return rand_bits(32);
        endcase
    endfunction

    task automatic present_bundle();
        ex_in_t     b;
        logic [4:0] code;
        code       = 5'(rand_bits(5) % 26 + 1);
        b.valid    = 1'b1;
        b.pc       = rand_bits(32) & 32'hffff_fffc;
        b.fun      = exe_fun_e'(code);
        b.op1      = rand_operand();
        b.op2      = rand_operand();
        b.rs2_data = rand_bits(32);
        b.imm_b    = rand_bits(32);
        b.rd       = 5'(rand_bits(5));
        b.rf_wen   = rand_bits(1) != 0;
        b.tag      = next_tag;
        next_tag   = next_tag + 8'd1;
        in_b       = b;
        hold_cycles = 0;
    endtask

    function automatic exp_t expect_for(input ex_in_t b);
        exp_t e;
        e.pc        = b.pc;
        e.alu_out   = result_ref(b.fun, b.op1, b.op2);
        e.rs2_data  = b.rs2_data;
        e.rd        = b.rd;
        e.rf_wen    = b.rf_wen;
        e.tag       = b.tag;
        e.br_taken  = branch_ref(b.fun, b.op1, b.op2);
        e.br_target = b.pc + b.imm_b;
        return e;
    endfunction

    // sample mid-cycle, check just after the edge, then drive
    task automatic step_cycle(input logic idle_after);
        exp_t e;
        @(negedge clk);
        accept_now = in_b.valid && !stall && !mem_stall && !flush;
        flush_now  = flush;
        if (!in_b.valid || !is_mcycle(in_b.fun)) begin
            check_value("stall", stall, 0);
        end else if (hold_cycles < 32) begin
            // multicycle op cannot finish this early
            check_value("stall", stall, 1);
        end
        @(posedge clk);
        #1;
        if (accept_now) begin
            exp_q.push_back(expect_for(in_b));
            n_accepted++;
        end
        if (flush_now) begin
            exp_q.delete();
        end
        check_value("out.valid", out_b.valid, accept_now);
        if (out_b.valid) begin
            e = exp_q.pop_front();
            check_value("out.pc", out_b.pc, e.pc);
            check_value("out.alu_out", out_b.alu_out, e.alu_out);
            check_value("out.rs2_data", out_b.rs2_data, e.rs2_data);
            check_value("out.rd", out_b.rd, e.rd);
            check_value("out.rf_wen", out_b.rf_wen, e.rf_wen);
            check_value("out.tag", out_b.tag, e.tag);
            check_value("br_taken", br_taken, e.br_taken);
            check_value("br_target", br_target, e.br_target);
        end else begin
            check_value("br_taken", br_taken, 0);
        end
        #1;
        if (flush_now) begin
            // bubble while the front end refetches
            in_b.valid = 1'b0;
            hold_cycles = 0;
        end else if (accept_now || !in_b.valid) begin
            if (idle_after) begin
                in_b.valid = 1'b0;
            end else begin
                present_bundle();
            end
        end else begin
            hold_cycles++;
        end
        mem_stall = rand_bits(3) == 0;
        flush     = rand_bits(8) < 6;
    endtask

    initial begin
        rst_n        = 1'b0;
        in_b         = '0;
        mem_stall    = 1'b0;
        flush        = 1'b0;
        lfsr         = 32'd10;
        n_accepted   = 0;
        hold_cycles  = 0;
        drain_cycles = 0;
        next_tag     = '0;
        repeat (3) @(posedge clk);
        #2;
        check_value("out.valid", out_b.valid, 0);
        check_value("br_taken", br_taken, 0);
        check_value("stall", stall, 0);
        rst_n = 1'b1;
        present_bundle();

        while (n_accepted < N_INSTR) begin
            step_cycle(1'b0);
            if (hold_cycles > TIMEOUT) begin
                $display("timeout: instruction %0h not accepted in %0d cycles",
                         in_b.tag, TIMEOUT);
                abort_run();
            end
        end

        while (exp_q.size() != 0 || in_b.valid) begin
            step_cycle(1'b1);
            drain_cycles++;
            if (drain_cycles > TIMEOUT) begin
                $display("timeout: pipeline did not drain in %0d cycles", TIMEOUT);
                abort_run();
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- exec_top.f
+incdir+tb
source/rv_exec_pkg.sv
source/alu.sv
source/mul_unit.sv
source/div_unit.sv
source/ex_stage.sv
source/exec_top.sv
tb/tb_exec_top.sv
